// ==== src/kernel_cu_pkg.sv ====
// Kernel compute unit package with sizing constants, encodings and packet types
`default_nettype none

package kernel_cu_pkg;

  // --------------------
  // Sizing
  // --------------------
  // Memory channels behind the unit
  localparam int NUM_CHANNELS = 2;
  // Bits needed to index a channel
  localparam int CH_W = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1;
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  // Line counts and tags share one width
  localparam int COUNT_W = 16;
  // One memory line, channel = line number mod NUM_CHANNELS
  localparam int LINE_BYTES = 64;
  localparam int LINE_SHIFT = $clog2(LINE_BYTES);
  // Idle cycles required before done may rise
  localparam int PULSE_HOLD = 4;
  localparam int HOLD_W = $clog2(PULSE_HOLD + 1);
  // Unused descriptor payload, kept for later fields
  localparam int DESC_SPARE_W = 8;

  // --------------------
  // Encodings
  // --------------------
  typedef enum logic [2:0] {
    IDLE       = 3'd0,
    SETUP      = 3'd1,
    SETUP_WAIT = 3'd2,
    RUN        = 3'd3,
    DRAIN      = 3'd4,
    DONE       = 3'd5
  } cu_state_e;

  // Configuration line read versus data line read
  typedef enum logic {
    OP_CFG_READ = 1'b0,
    OP_READ     = 1'b1
  } mem_opcode_e;

  // --------------------
  // Packet types
  // --------------------
  typedef struct packed {
    logic                    valid;
    logic [ADDR_W-1:0]       base_addr;
    logic [DESC_SPARE_W-1:0] spare;
  } kernel_descriptor_t;

  typedef struct packed {
    logic               valid;
    mem_opcode_e        opcode;
    logic [ADDR_W-1:0]  addr;
    logic [COUNT_W-1:0] tag;
  } mem_request_t;

  // Config response carries the line count in the low data bits
  typedef struct packed {
    logic               valid;
    mem_opcode_e        opcode;
    logic [DATA_W-1:0]  data;
    logic [COUNT_W-1:0] tag;
  } mem_response_t;

endpackage : kernel_cu_pkg

`default_nettype wire

// ==== src/cu_control_fsm.sv ====
// Job control FSM, sequences setup and run and tracks outstanding reads
`default_nettype none

module cu_control_fsm (
  input  logic                              ap_clk,
  input  logic                              areset_control,
  input  kernel_cu_pkg::kernel_descriptor_t descriptor,
  input  logic                              issue,
  input  logic                              all_issued,
  input  kernel_cu_pkg::mem_response_t      response,
  input  logic                              hold_met,
  output logic                              start_cfg,
  output logic                              start_run,
  output logic [kernel_cu_pkg::COUNT_W-1:0] line_count,
  output logic                              idle,
  output logic                              done_out
);

  import kernel_cu_pkg::*;

  cu_state_e          state;
  logic [COUNT_W-1:0] outstanding;
  logic               cfg_seen;

  // Configuration line has come back through the merge
  assign cfg_seen = response.valid && (response.opcode == OP_CFG_READ);

  // --------------------
  // State sequencing
  // --------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      state      <= IDLE;
      start_cfg  <= 1'b0;
      start_run  <= 1'b0;
      line_count <= '0;
    end else begin
      // Start strobes last one cycle
      start_cfg <= 1'b0;
      start_run <= 1'b0;
      case (state)
        IDLE, DONE: begin
          // A new descriptor also restarts from DONE
          if (descriptor.valid) begin
            state     <= SETUP;
            start_cfg <= 1'b1;
          end
        end
        SETUP: begin
          state <= SETUP_WAIT;
        end
        SETUP_WAIT: begin
          if (cfg_seen) begin
            line_count <= response.data[COUNT_W-1:0];
            start_run  <= 1'b1;
            state      <= RUN;
          end
        end
        RUN: begin
          // all_issued is stale during the start_run cycle
          if (!start_run && all_issued) begin
            state <= DRAIN;
          end
        end
        DRAIN: begin
          if (hold_met) begin
            state <= DONE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // --------------------
  // Outstanding reads
  // --------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      outstanding <= '0;
    end else begin
      case ({issue, response.valid})
        2'b10:   outstanding <= outstanding + 1'b1;
        2'b01:   outstanding <= outstanding - 1'b1;
        default: outstanding <= outstanding;
      endcase
    end
  end

  // Idle only once every read is back
  assign idle     = (state == DRAIN) && (outstanding == '0);
  assign done_out = (state == DONE);

  // Responses from the channels never outnumber the requests issued
  a_no_underflow: assert property (
    @(posedge ap_clk) disable iff (areset_control)
    response.valid |-> (outstanding != '0)
  ) else $error("response returned with no read outstanding");

endmodule : cu_control_fsm

`default_nettype wire

// ==== src/done_hold_timer.sv ====
// Done hold timer, confirms the idle level lasts for the hold period
`default_nettype none

module done_hold_timer (
  input  logic ap_clk,
  input  logic areset_control,
  input  logic idle,
  output logic hold_met
);

  import kernel_cu_pkg::*;

  logic [HOLD_W-1:0] idle_count;

  // Consecutive idle cycles, saturates at the hold length
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      idle_count <= '0;
    end else if (!idle) begin
      // Any busy cycle restarts the count
      idle_count <= '0;
    end else if (idle_count != HOLD_W'(PULSE_HOLD)) begin
      idle_count <= idle_count + 1'b1;
    end
  end

  assign hold_met = (idle_count == HOLD_W'(PULSE_HOLD));

endmodule : done_hold_timer

`default_nettype wire

// ==== src/request_gen.sv ====
// Request generator, emits the config read then one read per data line
`default_nettype none

module request_gen (
  input  logic                              ap_clk,
  input  logic                              areset_control,
  input  logic                              start_cfg,
  input  logic                              start_run,
  input  logic                              stall,
  input  logic [kernel_cu_pkg::ADDR_W-1:0]  base_addr,
  input  logic [kernel_cu_pkg::COUNT_W-1:0] line_count,
  output kernel_cu_pkg::mem_request_t       request,
  output logic                              issue,
  output logic                              all_issued
);

  import kernel_cu_pkg::*;

  // Reads left after the one being presented
  logic [COUNT_W-1:0] remaining;

  // Router takes the request whenever it does not stall
  assign issue = request.valid && !stall;

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      request.valid <= 1'b0;
      remaining     <= '0;
      all_issued    <= 1'b0;
    end else if (start_cfg) begin
      // Single configuration line at the descriptor base
      request.valid  <= 1'b1;
      request.opcode <= OP_CFG_READ;
      request.addr   <= base_addr;
      request.tag    <= '0;
      remaining      <= '0;
      all_issued     <= 1'b0;
    end else if (start_run) begin
      // Data lines start one line above the config line
      request.valid  <= (line_count != '0);
      request.opcode <= OP_READ;
      request.addr   <= base_addr + ADDR_W'(LINE_BYTES);
      request.tag    <= '0;
      remaining      <= line_count - 1'b1;
      all_issued     <= (line_count == '0);
    end else if (issue) begin
      if (remaining == '0) begin
        request.valid <= 1'b0;
        all_issued    <= 1'b1;
      end else begin
        // Next line, next tag
        request.addr <= request.addr + ADDR_W'(LINE_BYTES);
        request.tag  <= request.tag + 1'b1;
        remaining    <= remaining - 1'b1;
      end
    end
  end

endmodule : request_gen

`default_nettype wire

// ==== src/channel_router.sv ====
// Channel router, sends each request to its line's channel under back-pressure
`default_nettype none

module channel_router (
  input  logic                                   ap_clk,
  input  logic                                   areset_control,
  input  kernel_cu_pkg::mem_request_t            request,
  input  logic [kernel_cu_pkg::NUM_CHANNELS-1:0] ch_full,
  output kernel_cu_pkg::mem_request_t            ch_request [kernel_cu_pkg::NUM_CHANNELS],
  output logic                                   stall
);

  import kernel_cu_pkg::*;

  logic [CH_W-1:0] target;
  logic            accept;

  // Channel from the line number of the address
  assign target = CH_W'((request.addr >> LINE_SHIFT) % NUM_CHANNELS);

  // A request for a full channel stays put at the input
  assign stall  = request.valid && ch_full[target];
  assign accept = request.valid && !stall;

  // --------------------
  // Output registers
  // --------------------
  // One register per channel, valid is a one cycle strobe
  always_ff @(posedge ap_clk) begin
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      if (areset_control) begin
        ch_request[c].valid <= 1'b0;
      end else if (accept && (target == CH_W'(c))) begin
        ch_request[c] <= request;
      end else begin
        ch_request[c].valid <= 1'b0;
      end
    end
  end

  // Full seen by the router one cycle before the channel would see valid
  for (genvar g = 0; g < NUM_CHANNELS; g++) begin : g_full_check
    a_no_send_when_full: assert property (
      @(posedge ap_clk) disable iff (areset_control)
      ch_full[g] |=> !ch_request[g].valid
    ) else $error("request sent to full channel %0d", g);
  end

endmodule : channel_router

`default_nettype wire

// ==== src/response_merge.sv ====
// Response merge, collects channel responses round-robin into one stream
`default_nettype none

module response_merge (
  input  logic                                   ap_clk,
  input  logic                                   areset_control,
  input  kernel_cu_pkg::mem_response_t           ch_response [kernel_cu_pkg::NUM_CHANNELS],
  output logic [kernel_cu_pkg::NUM_CHANNELS-1:0] ch_hold,
  output kernel_cu_pkg::mem_response_t           response,
  output kernel_cu_pkg::mem_response_t           result_out
);

  import kernel_cu_pkg::*;

  mem_response_t   pend_q [NUM_CHANNELS];
  logic [CH_W-1:0] ptr_q;
  logic [CH_W-1:0] sel;
  logic            grant;

  // --------------------
  // Round-robin pick
  // --------------------
  // Search from the pointer, nearest pending channel wins
  always_comb begin
    int idx;
    sel   = ptr_q;
    grant = 1'b0;
    for (int i = NUM_CHANNELS - 1; i >= 0; i--) begin
      idx = (int'(ptr_q) + i) % NUM_CHANNELS;
      if (pend_q[idx].valid) begin
        sel   = CH_W'(idx);
        grant = 1'b1;
      end
    end
  end

  // Hold drops in the cycle the pending response is taken
  always_comb begin
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      ch_hold[c] = pend_q[c].valid && !(grant && (sel == CH_W'(c)));
    end
  end

  // --------------------
  // Pending registers
  // --------------------
  always_ff @(posedge ap_clk) begin
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      if (areset_control) begin
        pend_q[c].valid <= 1'b0;
      end else if (ch_response[c].valid) begin
        // Refill may land on the same edge as the take
        pend_q[c] <= ch_response[c];
      end else if (grant && (sel == CH_W'(c))) begin
        pend_q[c].valid <= 1'b0;
      end
    end
  end

  // Pointer moves past the channel just served
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      ptr_q <= '0;
    end else if (grant) begin
      ptr_q <= (sel == CH_W'(NUM_CHANNELS - 1)) ? '0 : sel + 1'b1;
    end
  end

  // Unselected slot is empty when nothing is granted
  assign response = pend_q[sel];

  // Data lines only, config line stays inside the unit
  always_comb begin
    result_out       = response;
    result_out.valid = response.valid && (response.opcode == OP_READ);
  end

  // Channel side must respect the hold level
  for (genvar g = 0; g < NUM_CHANNELS; g++) begin : g_hold_check
    a_no_resp_on_hold: assert property (
      @(posedge ap_clk) disable iff (areset_control)
      ch_hold[g] |-> !ch_response[g].valid
    ) else $error("response on channel %0d while held", g);
  end

endmodule : response_merge

`default_nettype wire

// ==== src/kernel_cu.sv ====
// Kernel compute unit top, registers the descriptor and joins the job blocks
`default_nettype none

module kernel_cu (
  input  logic                                   ap_clk,
  input  logic                                   areset_control,
  input  kernel_cu_pkg::kernel_descriptor_t      descriptor_in,
  output kernel_cu_pkg::mem_request_t            ch_request [kernel_cu_pkg::NUM_CHANNELS],
  input  logic [kernel_cu_pkg::NUM_CHANNELS-1:0] ch_full,
  input  kernel_cu_pkg::mem_response_t           ch_response [kernel_cu_pkg::NUM_CHANNELS],
  output logic [kernel_cu_pkg::NUM_CHANNELS-1:0] ch_hold,
  output kernel_cu_pkg::mem_response_t           result_out,
  output logic                                   done_out
);

  import kernel_cu_pkg::*;

  kernel_descriptor_t descriptor_q;
  mem_request_t       request;
  mem_response_t      response;
  logic [COUNT_W-1:0] line_count;
  logic               start_cfg;
  logic               start_run;
  logic               issue;
  logic               all_issued;
  logic               stall;
  logic               idle;
  logic               hold_met;

  // --------------------
  // Descriptor register
  // --------------------
  // Payload kept for the whole job, loaded only with a valid descriptor
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      descriptor_q.valid <= 1'b0;
    end else begin
      descriptor_q.valid <= descriptor_in.valid;
      if (descriptor_in.valid) begin
        descriptor_q.base_addr <= descriptor_in.base_addr;
        descriptor_q.spare     <= descriptor_in.spare;
      end
    end
  end

  // --------------------
  // Job blocks
  // --------------------
  cu_control_fsm cu_control_fsm_i (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .descriptor     (descriptor_q),
    .issue          (issue),
    .all_issued     (all_issued),
    .response       (response),
    .hold_met       (hold_met),
    .start_cfg      (start_cfg),
    .start_run      (start_run),
    .line_count     (line_count),
    .idle           (idle),
    .done_out       (done_out)
  );

  done_hold_timer done_hold_timer_i (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .idle           (idle),
    .hold_met       (hold_met)
  );

  request_gen request_gen_i (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .start_cfg      (start_cfg),
    .start_run      (start_run),
    .stall          (stall),
    .base_addr      (descriptor_q.base_addr),
    .line_count     (line_count),
    .request        (request),
    .issue          (issue),
    .all_issued     (all_issued)
  );

  // 1-to-N dispatch toward the memory channels
  channel_router channel_router_i (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .request        (request),
    .ch_full        (ch_full),
    .ch_request     (ch_request),
    .stall          (stall)
  );

  // N-to-1 collection back into the unit
  response_merge response_merge_i (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .ch_response    (ch_response),
    .ch_hold        (ch_hold),
    .response       (response),
    .result_out     (result_out)
  );

endmodule : kernel_cu

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
// Testbench clock and reset source, 8 ns clock with reset held for three cycles
`default_nettype none

module tb_clock_gen (
  output logic ap_clk,
  output logic areset_control
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD  = 4;
  localparam int RESET_CYCLES = 3;

  // Free running clock
  initial begin
    ap_clk = 1'b0;
    forever #HALF_PERIOD ap_clk = ~ap_clk;
  end

  // Reset spans three rising edges, released on a falling edge
  initial begin
    areset_control = 1'b1;
    repeat (RESET_CYCLES) @(posedge ap_clk);
    @(negedge ap_clk);
    areset_control = 1'b0;
  end

endmodule : tb_clock_gen

`default_nettype wire

// ==== test/kernel_cu_tb.sv ====
// Kernel compute unit testbench, table of jobs against a two channel memory model
`default_nettype none

module kernel_cu_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import kernel_cu_pkg::*;

  // --------------------
  // Table and types
  // --------------------
  typedef struct packed {
    logic [ADDR_W-1:0]  base_addr;
    logic [COUNT_W-1:0] line_count;
    logic               back_pressure;
  } test_row_t;

  // Request with its channel, due cycle only used by the memory model
  typedef struct packed {
    logic [CH_W-1:0] ch;
    logic [31:0]     due;
    mem_request_t    req;
  } chan_req_t;

  localparam int NUM_ROWS = 6;
  // Read data is the line address scrambled with this key
  localparam logic [DATA_W-1:0] DATA_KEY = 32'hA5C3_5A3C;

  // Base address, line count, random back-pressure
  test_row_t rows [NUM_ROWS] = '{
    '{32'h0000_1000, 16'd4, 1'b0},
    '{32'h0000_2040, 16'd7, 1'b0},
    '{32'h0000_3000, 16'd0, 1'b0},
    '{32'h0001_0040, 16'd9, 1'b1},
    '{32'h0002_0000, 16'd5, 1'b1},
    '{32'h0000_4080, 16'd0, 1'b1}
  };

  logic               ap_clk;
  logic               areset_control;
  kernel_descriptor_t descriptor_in;
  mem_request_t       ch_request [NUM_CHANNELS];
  logic [NUM_CHANNELS-1:0] ch_full;
  mem_response_t      ch_response [NUM_CHANNELS];
  logic [NUM_CHANNELS-1:0] ch_hold;
  mem_response_t      result_out;
  logic               done_out;

  // Scoreboard state for the running row
  chan_req_t          exp_q [$];
  chan_req_t          mem_q [$];
  bit                 seen_tag [int];
  int                 cur_count;
  logic [ADDR_W-1:0]  cur_base;
  logic               cur_bp;
  string              row_name;
  int                 results_seen;
  int                 last_result_cycle;
  int                 cycle_count;
  logic [15:0]        lfsr;
  int                 request_errors;
  int                 result_errors;
  int                 done_errors;
  int                 hold_errors;
  int                 other_errors;

  tb_clock_gen tb_clock_gen_i (
    .ap_clk         (ap_clk),
    .areset_control (areset_control)
  );

  kernel_cu kernel_cu_i (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .descriptor_in  (descriptor_in),
    .ch_request     (ch_request),
    .ch_full        (ch_full),
    .ch_response    (ch_response),
    .ch_hold        (ch_hold),
    .result_out     (result_out),
    .done_out       (done_out)
  );

  // --------------------
  // Helpers
  // --------------------
  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // Line number modulo channel count
  function automatic int channel_of(input logic [ADDR_W-1:0] addr);
    return int'((addr / ADDR_W'(LINE_BYTES)) % ADDR_W'(NUM_CHANNELS));
  endfunction

  // Data line k sits k+1 lines above the base
  function automatic logic [ADDR_W-1:0] line_addr(input logic [ADDR_W-1:0] base, input int tag);
    return base + ADDR_W'(LINE_BYTES) * ADDR_W'(tag + 1);
  endfunction

  function automatic int first_on_channel(input chan_req_t q [$], input int c);
    for (int i = 0; i < q.size(); i++) begin
      if (int'(q[i].ch) == c) begin
        return i;
      end
    end
    return -1;
  endfunction

  task automatic check_request(input string name, input mem_request_t exp,
                               input mem_request_t act);
    if ((exp.valid !== act.valid) || (exp.valid && (act !== exp))) begin
      request_errors++;
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_result(input string name, input mem_response_t exp,
                              input mem_response_t act);
    if ((exp.valid !== act.valid) || (exp.valid && (act !== exp))) begin
      result_errors++;
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_done(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      done_errors++;
      $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_hold(input string name, input logic [NUM_CHANNELS-1:0] exp,
                            input logic [NUM_CHANNELS-1:0] act);
    if (act !== exp) begin
      hold_errors++;
      $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic print_summary();
    $display("Errors: request=%0d result=%0d done=%0d hold=%0d other=%0d", request_errors,
             result_errors, done_errors, hold_errors, other_errors);
  endtask

  // --------------------
  // One clock cycle
  // --------------------
  // Sample on the falling edge, then drive the memory side for the next edge
  task automatic step_cycle();
    int            idx;
    int            tag;
    mem_response_t exp_res;
    mem_response_t resp;
    chan_req_t     ent;
    @(negedge ap_clk);
    cycle_count++;
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      if (ch_request[c].valid) begin
        // ch_full still holds what the DUT saw on the last edge
        if (ch_full[c]) begin
          other_errors++;
          $display("Request sent to channel %0d while it was full at %0t", c, $time);
        end
        idx = first_on_channel(exp_q, c);
        if (idx < 0) begin
          other_errors++;
          $display("Unexpected request on channel %0d: %h", c, ch_request[c]);
        end else begin
          if ((idx != 0) && (exp_q[0].req.opcode == OP_CFG_READ)) begin
            other_errors++;
            $display("%s: data request issued ahead of the config read", row_name);
          end
          check_request($sformatf("%s request ch%0d", row_name, c), exp_q[idx].req,
                        ch_request[c]);
          exp_q.delete(idx);
        end
        ent     = '0;
        ent.ch  = CH_W'(c);
        ent.due = 32'(cycle_count + 2);
        ent.req = ch_request[c];
        mem_q.push_back(ent);
      end
    end
    // Results may come in any order across channels
    if (result_out.valid) begin
      tag = int'(result_out.tag);
      last_result_cycle = cycle_count;
      if ((tag >= cur_count) || seen_tag.exists(tag)) begin
        other_errors++;
        $display("%s: result tag %0d is out of range or repeated", row_name, tag);
      end else begin
        exp_res        = '0;
        exp_res.valid  = 1'b1;
        exp_res.opcode = OP_READ;
        exp_res.data   = line_addr(cur_base, tag) ^ DATA_KEY;
        exp_res.tag    = COUNT_W'(tag);
        check_result($sformatf("%s result tag %0d", row_name, tag), exp_res, result_out);
        seen_tag[tag] = 1'b1;
        results_seen++;
      end
    end
    // Memory model, oldest due read per channel unless held
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      resp = '0;
      idx  = first_on_channel(mem_q, c);
      if (!ch_hold[c] && (idx >= 0) && (int'(mem_q[idx].due) <= cycle_count)) begin
        resp.valid  = 1'b1;
        resp.opcode = mem_q[idx].req.opcode;
        resp.tag    = mem_q[idx].req.tag;
        if (mem_q[idx].req.opcode == OP_CFG_READ) begin
          resp.data = DATA_W'(cur_count);
        end else begin
          resp.data = mem_q[idx].req.addr ^ DATA_KEY;
        end
        mem_q.delete(idx);
      end
      ch_response[c] = resp;
    end
    // One LFSR step per full bit
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      if (cur_bp) begin
        lfsr       = lfsr_next(lfsr);
        ch_full[c] = lfsr[0];
      end else begin
        ch_full[c] = 1'b0;
      end
    end
  endtask

  // --------------------
  // One table row
  // --------------------
  task automatic run_row(input int idx);
    test_row_t row;
    chan_req_t ent;
    row               = rows[idx];
    row_name          = $sformatf("row%0d", idx);
    cur_count         = int'(row.line_count);
    cur_base          = row.base_addr;
    cur_bp            = row.back_pressure;
    results_seen      = 0;
    last_result_cycle = cycle_count;
    seen_tag.delete();
    // Config read first, then data lines in tag order
    ent             = '0;
    ent.ch          = CH_W'(channel_of(row.base_addr));
    ent.req.valid   = 1'b1;
    ent.req.opcode  = OP_CFG_READ;
    ent.req.addr    = row.base_addr;
    exp_q.push_back(ent);
    for (int k = 0; k < cur_count; k++) begin
      ent.req.opcode = OP_READ;
      ent.req.addr   = line_addr(row.base_addr, k);
      ent.req.tag    = COUNT_W'(k);
      ent.ch         = CH_W'(channel_of(ent.req.addr));
      exp_q.push_back(ent);
    end
    descriptor_in.valid     = 1'b1;
    descriptor_in.base_addr = row.base_addr;
    descriptor_in.spare     = DESC_SPARE_W'(idx);
    step_cycle();
    descriptor_in.valid = 1'b0;
    // FSM has taken the registered descriptor by now
    step_cycle();
    check_done({row_name, " done cleared"}, 1'b0, done_out);
    while (!done_out) begin
      step_cycle();
      if (done_out && ((results_seen != cur_count) || (exp_q.size() != 0))) begin
        check_done({row_name, " early done"}, 1'b0, done_out);
      end
    end
    // Idle hold plus the done register after the last return
    if ((cur_count > 0) && ((cycle_count - last_result_cycle) < (PULSE_HOLD + 1))) begin
      other_errors++;
      $display("%s: done rose %0d cycles after the last result, before the idle hold ended",
               row_name, cycle_count - last_result_cycle);
    end
    if (mem_q.size() != 0) begin
      other_errors++;
      $display("%s: %0d reads still unanswered when done rose", row_name, mem_q.size());
    end
    exp_q.delete();
    mem_q.delete();
    // Done level holds until the next descriptor
    repeat (3) begin
      step_cycle();
      check_done({row_name, " done held"}, 1'b1, done_out);
      check_hold({row_name, " hold idle"}, '0, ch_hold);
    end
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    descriptor_in  = '0;
    ch_full        = '0;
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      ch_response[c] = '0;
    end
    lfsr              = 16'd4;
    cur_count         = 0;
    cur_base          = '0;
    cur_bp            = 1'b0;
    row_name          = "reset";
    results_seen      = 0;
    last_result_cycle = 0;
    cycle_count       = 0;
    request_errors    = 0;
    result_errors     = 0;
    done_errors       = 0;
    hold_errors       = 0;
    other_errors      = 0;
    @(negedge areset_control);
    // Quiet outputs before any descriptor
    repeat (4) begin
      step_cycle();
      check_done("reset done", 1'b0, done_out);
      check_hold("reset hold", '0, ch_hold);
      for (int c = 0; c < NUM_CHANNELS; c++) begin
        check_request("reset request", '0, ch_request[c]);
      end
      check_result("reset result", '0, result_out);
    end
    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(i);
    end
    print_summary();
    if ((request_errors + result_errors + done_errors + hold_errors + other_errors) == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Budget of 40 cycles per memory line in the table plus margin
  initial begin : watchdog
    int limit;
    limit = 100;
    for (int i = 0; i < NUM_ROWS; i++) begin
      limit += 40 * (int'(rows[i].line_count) + 1);
    end
    repeat (limit) @(posedge ap_clk);
    $display("Timeout: run did not finish within %0d clock cycles", limit);
    print_summary();
    $display("Regression failed");
    $finish;
  end

endmodule : kernel_cu_tb

`default_nettype wire

// ==== sim.f ====
src/kernel_cu_pkg.sv
src/cu_control_fsm.sv
src/done_hold_timer.sv
src/request_gen.sv
src/channel_router.sv
src/response_merge.sv
src/kernel_cu.sv
test/tb_clock_gen.sv
test/kernel_cu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= kernel_cu_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
SIM_FLAGS ?= -Wno-fatal
PASS_TEXT ?= Regression passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) $(SIM_FLAGS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$($(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
